/* Bender.yml */
package:
  name: poker_table

sources:
  - common/poker_pkg.sv
  - design/action_port.sv
  - design/table_mode.sv
  - betting/round_sequencer.sv
  - betting/chip_ledger.sv
  - design/poker_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/poker_tb.sv

/* betting/chip_ledger.sv */
`timescale 1ns/1ps
`default_nettype none

module chip_ledger
    import poker_pkg::*;
#(
    parameter chip_t START_BALANCE = DEFAULT_START_BALANCE,
    parameter chip_t RAISE_STEP    = DEFAULT_RAISE_STEP
) (
    input  wire             clk,
    input  wire             reset_d,
    input  wire             new_session,
    input  wire ledger_op_t ledger_op,
    input  wire player_t    act_player,
    input  wire player_t    award_to,
    output logic            bet_open,
    output chip_t           pot,
    output chip_t           p1_balance,
    output chip_t           p2_balance
);

    chip_t cur_bet;
    chip_t p1_stake;
    chip_t p2_stake;
    chip_t actor_stake;
    chip_t owed;
    chip_t pay;
    chip_t raised_bet;
    chip_t pot_paid;
    chip_t p1_paid;
    chip_t p2_paid;

    assign bet_open    = (cur_bet != '0);
    assign actor_stake = (act_player == player_one) ? p1_stake : p2_stake;
    assign owed        = cur_bet - actor_stake;
    assign raised_bet  = cur_bet + RAISE_STEP;

    always_comb begin
        case (ledger_op)
            op_call, op_award: pay = owed;
            op_raise:          pay = owed + RAISE_STEP;
            default:           pay = '0;
        endcase
    end

    // Balances wrap on overdraw
    assign pot_paid = pot + pay;
    assign p1_paid  = (act_player == player_one) ? p1_balance - pay : p1_balance;
    assign p2_paid  = (act_player == player_two) ? p2_balance - pay : p2_balance;

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            p1_balance <= START_BALANCE;
            p2_balance <= START_BALANCE;
            pot        <= '0;
            cur_bet    <= '0;
            p1_stake   <= '0;
            p2_stake   <= '0;
        end else if (new_session) begin
            p1_balance <= START_BALANCE;
            p2_balance <= START_BALANCE;
            pot        <= '0;
            cur_bet    <= '0;
            p1_stake   <= '0;
            p2_stake   <= '0;
        end else begin
            case (ledger_op)
                op_call, op_clear_street: begin
                    p1_balance <= p1_paid;
                    p2_balance <= p2_paid;
                    pot        <= pot_paid;
                    cur_bet    <= '0;  // A call always closes the street
                    p1_stake   <= '0;
                    p2_stake   <= '0;
                end
                op_raise: begin
                    p1_balance <= p1_paid;
                    p2_balance <= p2_paid;
                    pot        <= pot_paid;
                    cur_bet    <= raised_bet;
                    if (act_player == player_one) begin
                        p1_stake <= raised_bet;
                    end else begin
                        p2_stake <= raised_bet;
                    end
                end
                op_award: begin
                    p1_balance <= (award_to == player_one) ? p1_paid + pot_paid : p1_paid;
                    p2_balance <= (award_to == player_two) ? p2_paid + pot_paid : p2_paid;
                    pot        <= '0;
                    cur_bet    <= '0;
                    p1_stake   <= '0;
                    p2_stake   <= '0;
                end
                default: begin
                    pot <= pot;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* betting/round_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module round_sequencer
    import poker_pkg::*;
(
    input  wire          clk,
    input  wire          reset_d,
    input  wire          new_session,
    input  wire          action_valid,
    input  wire action_t action_code,
    input  wire          bet_open,
    output street_t      street,
    output player_t      current_player,
    output hand_count_t  hand_count,
    output ledger_op_t   ledger_op,
    output player_t      act_player,
    output player_t      award_to
);

    player_t start_player;
    player_t second_player;
    player_t opponent;
    player_t player_nxt;
    logic    street_end;
    logic    hand_end;

    assign start_player  = player_t'(hand_count[0]);  // Even hands open with player one
    assign second_player = player_t'(~hand_count[0]);
    assign opponent      = player_t'(~current_player);

    always_comb begin
        ledger_op  = op_none;
        act_player = current_player;
        award_to   = player_one;
        player_nxt = current_player;
        street_end = 1'b0;
        hand_end   = 1'b0;
        if (action_valid) begin
            case (action_code)
                act_fold: begin
                    ledger_op  = op_award;
                    award_to   = opponent;
                    act_player = opponent;  // The raiser owes nothing, so no call is settled
                    hand_end   = 1'b1;
                end
                act_call: begin
                    if (bet_open || current_player == second_player) begin
                        street_end = 1'b1;
                    end else begin
                        player_nxt = opponent;  // Opening check
                    end
                end
                act_raise: begin
                    ledger_op  = op_raise;
                    player_nxt = opponent;
                end
                default: begin
                    ledger_op = op_none;
                end
            endcase
            if (street_end) begin
                if (street == river) begin
                    // Showdown without evaluation; the caller still pays in
                    ledger_op = op_award;
                    hand_end  = 1'b1;
                end else begin
                    ledger_op  = bet_open ? op_call : op_clear_street;
                    player_nxt = start_player;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            street         <= preflop;
            current_player <= player_one;
            hand_count     <= '0;
        end else if (new_session) begin
            street         <= preflop;
            current_player <= player_one;
            hand_count     <= '0;
        end else if (hand_end) begin
            street         <= preflop;
            current_player <= second_player;  // Starts the next hand
            hand_count     <= hand_count + 1'b1;
        end else begin
            if (street_end) begin
                street <= street_t'(street + 2'd1);
            end
            current_player <= player_nxt;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+tests
common/poker_pkg.sv
design/action_port.sv
design/table_mode.sv
betting/round_sequencer.sv
betting/chip_ledger.sv
design/poker_top.sv
tests/poker_tb.sv

/* common/poker_pkg.sv */
`default_nettype none

package poker_pkg;

    typedef logic [6:0] chip_t;
    typedef logic [7:0] hand_count_t;

    typedef enum logic [1:0] {
        preflop = 2'd0,
        flop    = 2'd1,
        turn    = 2'd2,
        river   = 2'd3
    } street_t;

    typedef enum logic [1:0] {
        mode_playing = 2'd0,
        mode_cashout = 2'd1,
        mode_freeze  = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        act_fold  = 2'd0,
        act_call  = 2'd1,  // Acts as a check while no bet is open
        act_raise = 2'd2
    } action_t;

    typedef enum logic {
        player_one = 1'b0,
        player_two = 1'b1
    } player_t;

    typedef enum logic [2:0] {
        op_none         = 3'd0,
        op_call         = 3'd1,
        op_raise        = 3'd2,
        op_award        = 3'd3,
        op_clear_street = 3'd4
    } ledger_op_t;

    localparam chip_t DEFAULT_START_BALANCE = 7'd49;
    localparam chip_t DEFAULT_RAISE_STEP    = 7'd5;

endpackage

`default_nettype wire

/* design/action_port.sv */
`timescale 1ns/1ps
`default_nettype none

module action_port
    import poker_pkg::*;
(
    input  wire          clk,
    input  wire          reset_d,
    input  wire action_t action,
    input  wire          action_req,
    input  wire mode_t   mode,
    output logic         action_ack,
    output logic         action_valid,
    output action_t      action_code
);

    logic accept;

    // A request in flight blocks a second accept until ack has risen
    assign accept = action_req && !action_ack && !action_valid && (mode == mode_playing);

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            action_valid <= 1'b0;
            action_ack   <= 1'b0;
        end else begin
            action_valid <= accept;
            if (action_valid) begin
                action_ack <= 1'b1;  // Outputs already carry the action here
            end else if (!action_req) begin
                action_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            action_code <= action;
        end
    end

endmodule

`default_nettype wire

/* design/poker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module poker_top
    import poker_pkg::*;
#(
    parameter chip_t START_BALANCE = DEFAULT_START_BALANCE,
    parameter chip_t RAISE_STEP    = DEFAULT_RAISE_STEP
) (
    input  wire          clk,
    input  wire          reset_d,
    input  wire action_t action,
    input  wire          action_req,
    input  wire          cashout_hold,
    input  wire          freeze_hold,
    output logic         action_ack,
    output mode_t        mode,
    output street_t      street,
    output player_t      current_player,
    output hand_count_t  hand_count,
    output chip_t        pot,
    output chip_t        p1_balance,
    output chip_t        p2_balance
);

    logic       action_valid;
    action_t    action_code;
    logic       new_session;
    logic       bet_open;
    ledger_op_t ledger_op;
    player_t    act_player;
    player_t    award_to;

    action_port u_action_port (
        .clk          (clk),
        .reset_d      (reset_d),
        .action       (action),
        .action_req   (action_req),
        .mode         (mode),
        .action_ack   (action_ack),
        .action_valid (action_valid),
        .action_code  (action_code)
    );

    table_mode u_table_mode (
        .clk          (clk),
        .reset_d      (reset_d),
        .cashout_hold (cashout_hold),
        .freeze_hold  (freeze_hold),
        .street       (street),
        .mode         (mode),
        .new_session  (new_session)
    );

    round_sequencer u_round_sequencer (
        .clk            (clk),
        .reset_d        (reset_d),
        .new_session    (new_session),
        .action_valid   (action_valid),
        .action_code    (action_code),
        .bet_open       (bet_open),
        .street         (street),
        .current_player (current_player),
        .hand_count     (hand_count),
        .ledger_op      (ledger_op),
        .act_player     (act_player),
        .award_to       (award_to)
    );

    chip_ledger #(
        .START_BALANCE (START_BALANCE),
        .RAISE_STEP    (RAISE_STEP)
    ) u_chip_ledger (
        .clk         (clk),
        .reset_d     (reset_d),
        .new_session (new_session),
        .ledger_op   (ledger_op),
        .act_player  (act_player),
        .award_to    (award_to),
        .bet_open    (bet_open),
        .pot         (pot),
        .p1_balance  (p1_balance),
        .p2_balance  (p2_balance)
    );

endmodule

`default_nettype wire

/* design/table_mode.sv */
`timescale 1ns/1ps
`default_nettype none

module table_mode
    import poker_pkg::*;
(
    input  wire          clk,
    input  wire          reset_d,
    input  wire          cashout_hold,
    input  wire          freeze_hold,
    input  wire street_t street,
    output mode_t        mode,
    output logic         new_session
);

    mode_t saved_mode;  // Mode to resume when freeze is released

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            mode        <= mode_playing;
            saved_mode  <= mode_playing;
            new_session <= 1'b0;
        end else begin
            new_session <= 1'b0;
            case (mode)
                mode_playing: begin
                    if (freeze_hold) begin
                        mode       <= mode_freeze;
                        saved_mode <= mode_playing;
                    end else if (cashout_hold && street == preflop) begin
                        mode <= mode_cashout;  // Only between hands
                    end
                end
                mode_cashout: begin
                    if (freeze_hold) begin
                        mode       <= mode_freeze;
                        saved_mode <= mode_cashout;
                    end else if (!cashout_hold) begin
                        mode        <= mode_playing;
                        new_session <= 1'b1;  // High while mode first reads playing
                    end
                end
                mode_freeze: begin
                    if (!freeze_hold) begin
                        mode <= saved_mode;
                    end
                end
                default: begin
                    mode <= mode_playing;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tests/poker_tb_tasks.svh */
`ifndef POKER_TB_TASKS_SVH
`define POKER_TB_TASKS_SVH

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        test_checks++;
        total_checks++;
        assert (got === expected) else begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic close_test(input string name);
        test_number++;
        $display("Test %0d (%s) finished: %0d checks, %0d errors",
                 test_number, name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // Inputs change half a nanosecond after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s after %0d cycles",
                 $time, what, WAIT_LIMIT);
        total_errors++;
        finish_run();
    endtask

    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (action_ack !== level && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (action_ack !== level) begin
            abort_on_timeout(what);
        end
    endtask

    task automatic wait_for_mode(input mode_t target, input string what);
        int cycles;
        cycles = 0;
        while (mode !== target && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (mode !== target) begin
            abort_on_timeout(what);
        end
    endtask

    task automatic raise_request(input action_t act);
        action     = act;
        action_req = 1'b1;
    endtask

    // Outputs already carry the action once ack is high
    task automatic complete_request(input action_t act);
        wait_for_ack(1'b1, "action_ack to rise");
        predict_action(act);
        check_outputs();
        action_req = 1'b0;
        wait_for_ack(1'b0, "action_ack to fall");
        check_outputs();
    endtask

    task automatic send_action(input action_t act);
        raise_request(act);
        complete_request(act);
    endtask

`endif

/* tests/poker_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module poker_tb
    import poker_pkg::*;
();

    localparam chip_t START      = DEFAULT_START_BALANCE;
    localparam chip_t STEP       = DEFAULT_RAISE_STEP;
    localparam int    WAIT_LIMIT = 50;

    logic        clk;
    logic        reset_d;
    action_t     action;
    logic        action_req;
    logic        cashout_hold;
    logic        freeze_hold;
    logic        action_ack;
    mode_t       mode;
    street_t     street;
    player_t     current_player;
    hand_count_t hand_count;
    chip_t       pot;
    chip_t       p1_balance;
    chip_t       p2_balance;

    street_t     exp_street;
    player_t     exp_player;
    hand_count_t exp_hands;
    chip_t       exp_pot;
    chip_t       exp_bet;
    chip_t       exp_bal[2];    // Index 0 is player one
    chip_t       exp_stake[2];

    int      total_checks;
    int      total_errors;
    int      test_checks;
    int      test_errors;
    int      test_number;
    int      rnd;
    action_t pick;

    poker_top #(
        .START_BALANCE (START),
        .RAISE_STEP    (STEP)
    ) dut_i (
        .clk            (clk),
        .reset_d        (reset_d),
        .action         (action),
        .action_req     (action_req),
        .cashout_hold   (cashout_hold),
        .freeze_hold    (freeze_hold),
        .action_ack     (action_ack),
        .mode           (mode),
        .street         (street),
        .current_player (current_player),
        .hand_count     (hand_count),
        .pot            (pot),
        .p1_balance     (p1_balance),
        .p2_balance     (p2_balance)
    );

    always #2 clk = ~clk;

    ack_follows_req: assert property (@(posedge clk) disable iff (reset_d)
        $rose(action_ack) |-> $past(action_req))
        else begin
            $display("Error at %0t: action_ack rose with no request pending", $time);
            test_errors++;
            total_errors++;
        end

    task automatic reset_reference();
        exp_street = preflop;
        exp_player = player_one;
        exp_hands  = '0;
        exp_pot    = '0;
        exp_bet    = '0;
        exp_bal    = '{START, START};
        exp_stake  = '{default: '0};
    endtask

    task automatic pay_in(input int who, input chip_t amount);
        exp_bal[who] = exp_bal[who] - amount;  // Wraps on overdraw like the table
        exp_pot      = exp_pot + amount;
    endtask

    task automatic award_pot(input int winner);
        exp_bal[winner] = exp_bal[winner] + exp_pot;
        exp_pot         = '0;
        exp_bet         = '0;
        exp_stake       = '{default: '0};
    endtask

    task automatic end_hand();
        exp_street = preflop;
        exp_player = exp_hands[0] ? player_one : player_two;  // Odd count hands over to one
        exp_hands  = exp_hands + 1'b1;
    endtask

    task automatic predict_action(input action_t act);
        int    me;
        int    other;
        logic  second_to_act;
        chip_t owed;
        me            = int'(exp_player);
        other         = 1 - me;
        second_to_act = (me != int'(exp_hands[0]));
        owed          = exp_bet - exp_stake[me];
        if (act == act_fold) begin
            award_pot(other);
            end_hand();
        end else if (act == act_raise) begin
            pay_in(me, owed + STEP);
            exp_bet       = exp_bet + STEP;
            exp_stake[me] = exp_bet;
            exp_player    = player_t'(other);
        end else if (exp_bet == '0 && !second_to_act) begin
            exp_player = player_t'(other);  // Opening check passes the turn
        end else begin
            pay_in(me, owed);
            if (exp_street == river) begin
                award_pot(0);  // Showdown goes to player one
                end_hand();
            end else begin
                exp_bet    = '0;
                exp_stake  = '{default: '0};
                exp_street = street_t'(exp_street + 1);
                exp_player = player_t'(exp_hands[0]);
            end
        end
    endtask

    task automatic check_outputs();
        check_value("mode", mode, mode_playing);
        check_value("street", street, exp_street);
        check_value("current_player", current_player, exp_player);
        check_value("hand_count", hand_count, exp_hands);
        check_value("pot", pot, exp_pot);
        check_value("p1_balance", p1_balance, exp_bal[0]);
        check_value("p2_balance", p2_balance, exp_bal[1]);
    endtask

    task automatic finish_run();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_number, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        rnd          = $urandom(32'h5050_36f1);
        clk          = 1'b0;
        reset_d      = 1'b1;
        action       = act_fold;
        action_req   = 1'b0;
        cashout_hold = 1'b0;
        freeze_hold  = 1'b0;
        total_checks = 0;
        total_errors = 0;
        test_checks  = 0;
        test_errors  = 0;
        test_number  = 0;
        reset_reference();
        repeat (16) @(posedge clk);
        #0.5;
        reset_d = 1'b0;

        check_value("action_ack", action_ack, 0);
        check_outputs();
        close_test("reset values");

        send_action(act_raise);
        send_action(act_raise);
        send_action(act_call);
        check_value("pot", pot, 4 * STEP);
        check_value("p2_balance", p2_balance, START - 2 * STEP);
        close_test("raise, re-raise and call");

        repeat (6) send_action(act_call);
        check_value("p1_balance", p1_balance, START + 2 * STEP);
        check_value("current_player", current_player, player_two);
        close_test("checks to showdown");

        send_action(act_call);
        send_action(act_call);
        send_action(act_raise);
        send_action(act_raise);
        send_action(act_fold);
        check_value("p1_balance", p1_balance, START + 3 * STEP);
        check_value("street", street, preflop);
        close_test("fold mid-hand");

        freeze_hold = 1'b1;
        wait_for_mode(mode_freeze, "freeze entry");
        raise_request(act_raise);
        repeat (10) begin
            next_cycle();
            check_value("action_ack", action_ack, 0);
        end
        freeze_hold = 1'b0;
        wait_for_mode(mode_playing, "return from freeze");
        complete_request(act_raise);
        repeat (4) next_cycle();
        check_outputs();  // A repeated raise would have moved the pot again
        check_value("pot", pot, STEP);
        send_action(act_fold);
        close_test("freeze back-pressure");

        send_action(act_call);
        send_action(act_call);
        cashout_hold = 1'b1;
        repeat (6) begin
            next_cycle();
            check_value("mode", mode, mode_playing);
        end
        cashout_hold = 1'b0;
        send_action(act_fold);
        send_action(act_raise);  // Chips left in the pot for the new session to clear
        cashout_hold = 1'b1;
        wait_for_mode(mode_cashout, "cashout entry");
        freeze_hold = 1'b1;
        wait_for_mode(mode_freeze, "freeze during cashout");
        freeze_hold = 1'b0;
        wait_for_mode(mode_cashout, "return to cashout");
        cashout_hold = 1'b0;
        wait_for_mode(mode_playing, "cashout release");
        next_cycle();  // New session lands one edge after the mode change
        reset_reference();
        check_outputs();
        repeat (200) begin
            rnd = $urandom % 8;
            if (rnd == 0) begin
                pick = act_fold;
            end else if (rnd < 4 || exp_bal[0] <= 2 * STEP || exp_bal[1] <= 2 * STEP) begin
                pick = act_call;
            end else begin
                pick = act_raise;
            end
            send_action(pick);
        end
        close_test("cashout and random play");
        finish_run();
    end

`include "poker_tb_tasks.svh"

endmodule

`default_nettype wire
